// ==== flist.f ====
+incdir+hw
hw/tap_pkg.sv
hw/axis_if.sv
hw/axis_tap.sv
hw/axis_frame_mux.sv
hw/dual_tap_top.sv
verif/tb_dual_tap.sv

// ==== hw/axis_frame_mux.sv ====
/* merges the two tap streams into one capture stream, a frame at a time
   grant alternates at frame ends and the link number rides with each beat */
`timescale 1ns/1ps
`default_nettype none

module axis_frame_mux (
    input  logic               clk,
    input  logic               rst,
    axis_if.sink               in0,
    axis_if.sink               in1,
    // capture stream
    output tap_pkg::tap_data_t capture_tdata,
    output logic               capture_tvalid,
    input  logic               capture_tready,
    output logic               capture_tlast,
    output logic               capture_tuser,
    output tap_pkg::link_id_t  capture_link
);

    tap_pkg::mux_state_e state_reg;
    tap_pkg::mux_state_e state_next;

    // input locked for the frame in progress
    tap_pkg::link_id_t grant_reg;
    // link whose frame finished most recently
    tap_pkg::link_id_t last_reg;
    tap_pkg::link_id_t sel;

    logic cap_beat;
    logic cap_end;

    // selection, fresh pick only while idle
    always_comb begin
        sel = grant_reg;
        if (state_reg == tap_pkg::mux_idle) begin
            if (in0.tvalid && in1.tvalid) begin
                // both waiting, serve the other one
                sel = ~last_reg;
            end else if (in1.tvalid) begin
                sel = tap_pkg::link_id_t'(1);
            end else begin
                sel = tap_pkg::link_id_t'(0);
            end
        end
    end

    always_comb begin
        if (sel == tap_pkg::link_id_t'(1)) begin
            capture_tdata  = in1.tdata;
            capture_tvalid = in1.tvalid;
            capture_tlast  = in1.tlast;
            capture_tuser  = in1.tuser;
        end else begin
            capture_tdata  = in0.tdata;
            capture_tvalid = in0.tvalid;
            capture_tlast  = in0.tlast;
            capture_tuser  = in0.tuser;
        end
    end

    assign capture_link = sel;

    // back-pressure goes to the granted input only
    assign in0.tready = capture_tready & (sel == tap_pkg::link_id_t'(0));
    assign in1.tready = capture_tready & (sel == tap_pkg::link_id_t'(1));

    assign cap_beat = capture_tvalid & capture_tready;
    assign cap_end  = cap_beat & capture_tlast;

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            tap_pkg::mux_idle: begin
                // single beat frames never leave idle
                if (cap_beat && !capture_tlast) begin
                    state_next = tap_pkg::mux_frame;
                end
            end
            tap_pkg::mux_frame: begin
                if (cap_end) begin
                    state_next = tap_pkg::mux_idle;
                end
            end
            default: begin
                state_next = tap_pkg::mux_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= tap_pkg::mux_idle;
            grant_reg <= '0;
            last_reg  <= '0;
        end else begin
            state_reg <= state_next;
            if (state_reg == tap_pkg::mux_idle && cap_beat) begin
                grant_reg <= sel;
            end
            if (cap_end) begin
                last_reg <= sel;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/axis_if.sv ====
/* byte stream bundle with valid/ready handshake, last and user
   source modport on the producer, sink modport on the consumer */
`timescale 1ns/1ps
`default_nettype none

interface axis_if;

    tap_pkg::tap_data_t tdata;
    logic               tvalid;
    logic               tready;
    // final beat of a frame
    logic               tlast;
    // set on a truncated frame
    logic               tuser;

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

`default_nettype wire

// ==== hw/axis_tap.sv ====
/* passive tap, copies accepted beats of one link onto a registered stream
   frames that find no room are dropped or cut short with a truncation beat */
`timescale 1ns/1ps
`default_nettype none

module axis_tap (
    input  logic               clk,
    input  logic               rst,
    // observed link, never driven
    input  tap_pkg::tap_data_t tap_tdata,
    input  logic               tap_tvalid,
    input  logic               tap_tready,
    input  logic               tap_tlast,
    input  logic               tap_tuser,
    // copied stream
    axis_if.source             out
);

    // beat taken by both ends of the link
    logic link_beat;

    tap_pkg::tap_state_e state_reg;
    tap_pkg::tap_state_e state_next;
    // link is inside a frame
    logic frame_reg;
    logic frame_next;

    // beat handed to the skid datapath
    tap_pkg::tap_data_t int_tdata;
    logic               int_tvalid;
    logic               int_tlast;
    logic               int_tuser;
    logic               ready_int_reg;
    logic               ready_int_early;

    assign link_beat = tap_tvalid & tap_tready;

    always_comb begin
        state_next = state_reg;
        frame_next = frame_reg;
        int_tdata  = '0;
        int_tvalid = 1'b0;
        int_tlast  = 1'b0;
        int_tuser  = 1'b0;

        if (link_beat) begin
            frame_next = ~tap_tlast;
        end

        case (state_reg)
            tap_pkg::tap_idle: begin
                if (link_beat) begin
                    if (ready_int_reg) begin
                        int_tdata  = tap_tdata;
                        int_tvalid = 1'b1;
                        int_tlast  = tap_tlast;
                        int_tuser  = tap_tuser;
                        state_next = tap_tlast ? tap_pkg::tap_idle : tap_pkg::tap_transfer;
                    end else if (!tap_tlast) begin
                        // no room at frame start, skip the whole frame
                        state_next = tap_pkg::tap_wait;
                    end
                end
            end
            tap_pkg::tap_transfer: begin
                if (link_beat) begin
                    if (ready_int_reg) begin
                        int_tdata  = tap_tdata;
                        int_tvalid = 1'b1;
                        int_tlast  = tap_tlast;
                        int_tuser  = tap_tuser;
                        state_next = tap_tlast ? tap_pkg::tap_idle : tap_pkg::tap_transfer;
                    end else begin
                        state_next = tap_pkg::tap_truncate;
                    end
                end
            end
            tap_pkg::tap_truncate: begin
                // one closing beat, zero data with last and user
                if (ready_int_reg) begin
                    int_tdata  = '0;
                    int_tvalid = 1'b1;
                    int_tlast  = 1'b1;
                    int_tuser  = 1'b1;
                    state_next = frame_next ? tap_pkg::tap_wait : tap_pkg::tap_idle;
                end
            end
            tap_pkg::tap_wait: begin
                // discard until the link frame ends
                if (link_beat && tap_tlast) begin
                    state_next = tap_pkg::tap_idle;
                end
            end
            default: begin
                state_next = tap_pkg::tap_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= tap_pkg::tap_idle;
            frame_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_reg <= frame_next;
        end
    end

    // output and temp registers of the skid
    tap_pkg::tap_data_t out_tdata_reg;
    logic               out_tvalid_reg;
    logic               out_tvalid_next;
    logic               out_tlast_reg;
    logic               out_tuser_reg;
    tap_pkg::tap_data_t tmp_tdata_reg;
    logic               tmp_tvalid_reg;
    logic               tmp_tvalid_next;
    logic               tmp_tlast_reg;
    logic               tmp_tuser_reg;

    logic int_to_out;
    logic int_to_tmp;
    logic tmp_to_out;

    assign out.tdata  = out_tdata_reg;
    assign out.tvalid = out_tvalid_reg;
    assign out.tlast  = out_tlast_reg;
    assign out.tuser  = out_tuser_reg;

    // ready next cycle unless the temp slot could fill up
    assign ready_int_early = out.tready |
                             (~tmp_tvalid_reg & (~out_tvalid_reg | ~int_tvalid));

    always_comb begin
        out_tvalid_next = out_tvalid_reg;
        tmp_tvalid_next = tmp_tvalid_reg;
        int_to_out      = 1'b0;
        int_to_tmp      = 1'b0;
        tmp_to_out      = 1'b0;

        if (ready_int_reg) begin
            if (out.tready || !out_tvalid_reg) begin
                out_tvalid_next = int_tvalid;
                int_to_out      = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_tvalid_next = int_tvalid;
                int_to_tmp      = 1'b1;
            end
        end else if (out.tready) begin
            out_tvalid_next = tmp_tvalid_reg;
            tmp_tvalid_next = 1'b0;
            tmp_to_out      = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid_reg <= 1'b0;
            tmp_tvalid_reg <= 1'b0;
            ready_int_reg  <= 1'b0;
        end else begin
            out_tvalid_reg <= out_tvalid_next;
            tmp_tvalid_reg <= tmp_tvalid_next;
            ready_int_reg  <= ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_tdata_reg <= int_tdata;
            out_tlast_reg <= int_tlast;
            out_tuser_reg <= int_tuser;
        end else if (tmp_to_out) begin
            out_tdata_reg <= tmp_tdata_reg;
            out_tlast_reg <= tmp_tlast_reg;
            out_tuser_reg <= tmp_tuser_reg;
        end

        if (int_to_tmp) begin
            tmp_tdata_reg <= int_tdata;
            tmp_tlast_reg <= int_tlast;
            tmp_tuser_reg <= int_tuser;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dual_tap_top.sv ====
/* dual-link passive capture unit, one tap per monitored link feeding the frame mux
   all link signals are observed inputs, the capture stream is the only output */
`timescale 1ns/1ps
`default_nettype none

module dual_tap_top (
    input  logic               clk,
    input  logic               rst,
    // link 0, observed only
    input  tap_pkg::tap_data_t link0_tdata,
    input  logic               link0_tvalid,
    input  logic               link0_tready,
    input  logic               link0_tlast,
    input  logic               link0_tuser,
    // link 1, observed only
    input  tap_pkg::tap_data_t link1_tdata,
    input  logic               link1_tvalid,
    input  logic               link1_tready,
    input  logic               link1_tlast,
    input  logic               link1_tuser,
    // merged capture stream
    output tap_pkg::tap_data_t capture_tdata,
    output logic               capture_tvalid,
    input  logic               capture_tready,
    output logic               capture_tlast,
    output logic               capture_tuser,
    output tap_pkg::link_id_t  capture_link
);

    // tap to mux streams
    axis_if tap0_bus ();
    axis_if tap1_bus ();

    axis_tap tap0 (
        .clk        (clk),
        .rst        (rst),
        .tap_tdata  (link0_tdata),
        .tap_tvalid (link0_tvalid),
        .tap_tready (link0_tready),
        .tap_tlast  (link0_tlast),
        .tap_tuser  (link0_tuser),
        .out        (tap0_bus.source)
    );

    axis_tap tap1 (
        .clk        (clk),
        .rst        (rst),
        .tap_tdata  (link1_tdata),
        .tap_tvalid (link1_tvalid),
        .tap_tready (link1_tready),
        .tap_tlast  (link1_tlast),
        .tap_tuser  (link1_tuser),
        .out        (tap1_bus.source)
    );

    axis_frame_mux mux (
        .clk            (clk),
        .rst            (rst),
        .in0            (tap0_bus.sink),
        .in1            (tap1_bus.sink),
        .capture_tdata  (capture_tdata),
        .capture_tvalid (capture_tvalid),
        .capture_tready (capture_tready),
        .capture_tlast  (capture_tlast),
        .capture_tuser  (capture_tuser),
        .capture_link   (capture_link)
    );

endmodule

`default_nettype wire

// ==== hw/tap_defines.svh ====
/* global widths for the dual-link stream capture unit
   include wherever beat or link widths are needed */
`ifndef TAP_DEFINES_SVH
`define TAP_DEFINES_SVH

// bits per stream beat
`define TAP_DATA_WIDTH 8

// number of monitored links
// the capture link number is sized from this
`define TAP_LINK_COUNT 2

`endif

// ==== hw/tap_pkg.sv ====
/* shared types of the capture unit, beat and link vectors plus FSM states
   referenced with scoped names from RTL and testbench */
`default_nettype none

`include "tap_defines.svh"

package tap_pkg;

    // one beat of stream data
    typedef logic [`TAP_DATA_WIDTH-1:0] tap_data_t;

    // source link of a captured frame
    typedef logic [$clog2(`TAP_LINK_COUNT)-1:0] link_id_t;

    // per-link tap FSM
    typedef enum logic [1:0] {
        tap_idle,
        tap_transfer,
        tap_truncate,
        tap_wait
    } tap_state_e;

    // frame mux FSM
    typedef enum logic {
        mux_idle,
        mux_frame
    } mux_state_e;

endpackage

`default_nettype wire

// ==== verif/tap_stim.txt ====
// link length user stall_on stall_off class, all hex, link 02 drives both links at once
// stall offsets in cycles from record start, ff leaves capture_tready unchanged
// class 00 whole, 01 truncated, 02 dropped, a link of ff ends the list
00 04 00 ff ff 00
01 04 01 ff ff 00
00 01 00 ff ff 00
01 09 00 ff ff 00
00 10 01 ff ff 00
02 02 00 ff ff 00
02 01 01 ff ff 00
02 02 01 ff ff 00
00 10 00 0b 1e 01
01 10 01 0b 1e 01
01 0c 00 0b ff 01
01 05 01 ff ff 02
01 06 00 ff 01 00
00 0c 01 0b ff 01
00 01 00 ff ff 02
00 07 01 ff 01 00
02 02 00 ff ff 00
01 03 01 ff ff 00
ff ff ff ff ff ff

// ==== verif/tb_dual_tap.sv ====
/* testbench for the dual-link capture unit, frames and stalls come from verif/tap_stim.txt
   a monitor rebuilds every captured frame and checks it against per-link expected queues */
`timescale 1ns/1ps
`default_nettype none

`include "tap_defines.svh"

module tb_dual_tap;

    localparam int MAX_RECORDS = 32;
    localparam int LEAD_CYCLES = 8;
    localparam int BEAT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 1000;
    localparam int CLS_WHOLE   = 0;
    localparam int CLS_TRUNC   = 1;
    localparam int CLS_DROP    = 2;

    logic                         clk;
    logic                         rst;
    tap_pkg::tap_data_t           lk_tdata [`TAP_LINK_COUNT];
    logic [`TAP_LINK_COUNT-1:0]   lk_tvalid;
    logic [`TAP_LINK_COUNT-1:0]   lk_tready;
    logic [`TAP_LINK_COUNT-1:0]   lk_tlast;
    logic [`TAP_LINK_COUNT-1:0]   lk_tuser;
    tap_pkg::tap_data_t           capture_tdata;
    logic                         capture_tvalid;
    logic                         capture_tready;
    logic                         capture_tlast;
    logic                         capture_tuser;
    tap_pkg::link_id_t            capture_link;

    // six hex fields per record as laid out in the stim file
    logic [7:0]         stim_mem [0:MAX_RECORDS*6-1];
    tap_pkg::tap_data_t frame_bytes [`TAP_LINK_COUNT][64];
    tap_pkg::tap_data_t bytes0 [$];
    tap_pkg::tap_data_t bytes1 [$];
    // frame descriptors with user at bit 10 and class at bits 9:8 above the length
    int                 desc0 [$];
    int                 desc1 [$];

    integer seed;
    int     err_count;
    int     frames_seen;
    int     rec;
    int     waited;
    logic   timed_out;

    // capture monitor state
    logic               in_frame;
    logic               cur_valid;
    tap_pkg::link_id_t  cur_link;
    int                 cur_len;
    int                 cur_cls;
    logic               cur_user;
    int                 beat_idx;

    dual_tap_top dut (
        .clk            (clk),
        .rst            (rst),
        .link0_tdata    (lk_tdata[0]),
        .link0_tvalid   (lk_tvalid[0]),
        .link0_tready   (lk_tready[0]),
        .link0_tlast    (lk_tlast[0]),
        .link0_tuser    (lk_tuser[0]),
        .link1_tdata    (lk_tdata[1]),
        .link1_tvalid   (lk_tvalid[1]),
        .link1_tready   (lk_tready[1]),
        .link1_tlast    (lk_tlast[1]),
        .link1_tuser    (lk_tuser[1]),
        .capture_tdata  (capture_tdata),
        .capture_tvalid (capture_tvalid),
        .capture_tready (capture_tready),
        .capture_tlast  (capture_tlast),
        .capture_tuser  (capture_tuser),
        .capture_link   (capture_link)
    );

    always #50 clk = ~clk;

    task automatic check_data(input string name, input tap_pkg::tap_data_t exp,
                              input tap_pkg::tap_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_link(input string name, input tap_pkg::link_id_t exp,
                              input tap_pkg::link_id_t act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns %s expected %0d got %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns %s expected %b got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    function automatic tap_pkg::tap_data_t next_byte(input int link);
        tap_pkg::tap_data_t b;
        b = '0;
        if (link == 0 && bytes0.size() > 0) begin
            b = bytes0.pop_front();
        end else if (link == 1 && bytes1.size() > 0) begin
            b = bytes1.pop_front();
        end else begin
            $display("error at %0d ns: link %0d captured more bytes than it sent", $time, link);
            err_count++;
        end
        return b;
    endfunction

    function automatic int pending_frames(input int link);
        return (link == 0) ? desc0.size() : desc1.size();
    endfunction

    task automatic take_frame(input int link);
        int d;
        d = (link == 0) ? desc0.pop_front() : desc1.pop_front();
        cur_len  = d & 8'hff;
        cur_cls  = (d >> 8) & 3;
        cur_user = ((d >> 10) & 1) != 0;
    endtask

    task automatic discard_bytes(input int link, input int count);
        int i;
        tap_pkg::tap_data_t dummy;
        for (i = 0; i < count; i++) begin
            dummy = next_byte(link);
        end
    endtask

    // bytes are fixed before the frame goes out
    task automatic queue_frame(input int link, input int len, input int cls, input int user);
        int i;
        tap_pkg::tap_data_t b;
        for (i = 0; i < len; i++) begin
            b = tap_pkg::tap_data_t'($random(seed));
            frame_bytes[link][i] = b;
            if (link == 0) bytes0.push_back(b);
            else bytes1.push_back(b);
        end
        if (link == 0) desc0.push_back((user << 10) | (cls << 8) | len);
        else desc1.push_back((user << 10) | (cls << 8) | len);
    endtask

    task automatic drive_frame(input int link, input int len, input int user);
        int   beat;
        int   tries;
        logic accepted;
        repeat (LEAD_CYCLES) begin
            @(posedge clk);
            #1;
        end
        beat = 0;
        while (beat < len && !timed_out) begin
            // optional idle cycle between beats
            if ($random(seed) & 1) begin
                lk_tvalid[link] = 1'b0;
                lk_tready[link] = ($random(seed) & 1) != 0;
                @(posedge clk);
                #1;
            end
            lk_tdata[link]  = frame_bytes[link][beat];
            lk_tlast[link]  = (beat == len - 1);
            lk_tuser[link]  = (user != 0);
            lk_tvalid[link] = 1'b1;
            accepted = 1'b0;
            tries    = 0;
            while (!accepted && tries < BEAT_LIMIT) begin
                lk_tready[link] = ($random(seed) & 3) != 0;
                accepted = lk_tready[link];
                @(posedge clk);
                #1;
                tries++;
            end
            if (!accepted) begin
                $display("timeout: sink of link %0d never accepted beat %0d", link, beat);
                timed_out = 1'b1;
                err_count++;
            end
            beat++;
        end
        lk_tvalid[link] = 1'b0;
        lk_tready[link] = 1'b0;
        lk_tlast[link]  = 1'b0;
    endtask

    // capture_tready changes at the given cycle offsets and ff means no change
    task automatic run_stall(input int on_cyc, input int off_cyc);
        int c;
        int last;
        last = 0;
        if (on_cyc != 8'hff && on_cyc > last) last = on_cyc;
        if (off_cyc != 8'hff && off_cyc > last) last = off_cyc;
        for (c = 0; c <= last; c++) begin
            if (c == on_cyc) capture_tready = 1'b0;
            if (c == off_cyc) capture_tready = 1'b1;
            @(posedge clk);
            #1;
        end
    endtask

    task run_record(input int idx);
        int link;
        int len;
        int user;
        int cls;
        link = stim_mem[idx*6];
        len  = stim_mem[idx*6+1];
        user = stim_mem[idx*6+2];
        cls  = stim_mem[idx*6+5];
        // link 2 sends the same kind of frame on both links at once
        if (link != 1) queue_frame(0, len, cls, user);
        if (link != 0) queue_frame(1, len, cls, user);
        fork
            run_stall(stim_mem[idx*6+3], stim_mem[idx*6+4]);
            if (link != 1) drive_frame(0, len, user);
            if (link != 0) drive_frame(1, len, user);
        join
        $display("test %0d link %0d length %0d class %0d done, errors %0d",
                 idx, link, len, cls, err_count);
    endtask

    always @(negedge clk) begin
        if (!rst && capture_tvalid && capture_tready) begin
            if (!in_frame) begin
                in_frame  = 1'b1;
                cur_valid = 1'b0;
                cur_link  = capture_link;
                beat_idx  = 0;
                // only a link with frames still owed can own a new frame
                if (pending_frames(1) == 0) begin
                    check_link("capture_link", tap_pkg::link_id_t'(0), capture_link);
                end else if (pending_frames(0) == 0) begin
                    check_link("capture_link", tap_pkg::link_id_t'(1), capture_link);
                end
                // frames the tap dropped leave only their bytes behind
                while (!cur_valid && pending_frames(cur_link) > 0) begin
                    take_frame(cur_link);
                    if (cur_cls == CLS_DROP) discard_bytes(cur_link, cur_len);
                    else cur_valid = 1'b1;
                end
                if (cur_valid) begin
                    frames_seen++;
                end else begin
                    $display("error at %0d ns: frame from link %0d was not expected",
                             $time, cur_link);
                    err_count++;
                end
            end else begin
                check_link("capture_link", cur_link, capture_link);
            end
            if (cur_valid && cur_cls == CLS_TRUNC && capture_tlast) begin
                check_data("capture_tdata", '0, capture_tdata);
                check_flag("capture_tuser", 1'b1, capture_tuser);
                if (beat_idx >= cur_len) begin
                    $display("error at %0d ns: truncated frame is not shorter than sent", $time);
                    err_count++;
                end
                // rest of the frame never reaches the capture
                discard_bytes(cur_link, cur_len - beat_idx);
            end else if (cur_valid) begin
                check_data("capture_tdata", next_byte(cur_link), capture_tdata);
                check_flag("capture_tlast", cur_cls == CLS_WHOLE && beat_idx == cur_len - 1,
                           capture_tlast);
                check_flag("capture_tuser", cur_user, capture_tuser);
                beat_idx++;
            end
            if (capture_tlast) in_frame = 1'b0;
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        lk_tdata[0]    = '0;
        lk_tdata[1]    = '0;
        lk_tvalid      = '0;
        lk_tready      = '0;
        lk_tlast       = '0;
        lk_tuser       = '0;
        capture_tready = 1'b1;
        seed           = 32'hd4f;
        err_count      = 0;
        frames_seen    = 0;
        timed_out      = 1'b0;
        in_frame       = 1'b0;
        cur_valid      = 1'b0;
        $readmemh("verif/tap_stim.txt", stim_mem);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // nothing may reach the capture while both links are idle
        repeat (12) begin
            @(negedge clk);
            check_flag("capture_tvalid", 1'b0, capture_tvalid);
        end
        $display("test idle after reset done, errors %0d", err_count);
        @(posedge clk);
        #1;
        rec = 0;
        while (rec < MAX_RECORDS && stim_mem[rec*6] <= 8'h02 && !timed_out) begin
            run_record(rec);
            rec++;
        end
        waited = 0;
        while ((pending_frames(0) + pending_frames(1) > 0 || in_frame) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            $display("timeout: expected frames never completed on the capture port");
            timed_out = 1'b1;
            err_count++;
        end
        $display("tests %0d, frames captured %0d, errors %0d", rec + 1, frames_seen, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
